/* design/capture_pkg.sv */
package capture_pkg;

   // ------------------------------
   // ring geometry
   // ------------------------------
   localparam int ADDR_W = 8;                 // fixed by the tile
   localparam int DEPTH  = 1 << ADDR_W;       // 256 entries
   localparam int TILE_W = 36;                // one lane per tile

   // ------------------------------
   // RAM port controls
   // ------------------------------
   typedef struct packed {
      logic              we;                  // write strobe
      logic [ADDR_W-1:0] waddr;               // ring slot
   } wr_ctl_t;

   typedef struct packed {
      logic              ce;                  // read enable, holds dout when low
      logic [ADDR_W-1:0] raddr;               // slot being fetched
   } rd_ctl_t;

   // ------------------------------
   // FSM states
   // ------------------------------
   typedef enum logic [2:0] {
      CAP_IDLE, CAP_PREFILL, CAP_ARMED, CAP_POST, CAP_DONE
   } cap_state_e;

   typedef enum logic [1:0] {
      DUMP_IDLE, DUMP_RUN, DUMP_DRAIN
   } dump_state_e;

endpackage

/* design/ramb8x36_sdp.sv */
module ramb8x36_sdp (
   input  logic                          RCLK,
   input  logic                          we,      // write port
   input  logic [capture_pkg::ADDR_W-1:0] waddr,
   input  logic [capture_pkg::TILE_W-1:0] din,
   input  logic                          ce,      // read port
   input  logic [capture_pkg::ADDR_W-1:0] raddr,
   output logic [capture_pkg::TILE_W-1:0] dout
);
   import capture_pkg::*;

   logic [TILE_W-1:0] mem [DEPTH];             // 256 x 36 storage

   // ------------------------------
   // write side
   // ------------------------------
   always_ff @(posedge RCLK) begin
      if (we) begin
         mem[waddr] <= din;                    // no byte enables
      end
   end

   // ------------------------------
   // read side
   // ------------------------------
   // registered read, the output latch doubles as the stall buffer
   always_ff @(posedge RCLK) begin
      if (ce) begin
         dout <= mem[raddr];                   // holds while ce low
      end
   end

   // a write to an unknown slot would corrupt the whole ring in simulation
   a_waddr_known : assert property (
      @(posedge RCLK) we |-> !$isunknown(waddr)
   ) else $error("ramb8x36_sdp: write with unknown address %h", waddr);

endmodule

/* design/capture_writer.sv */
module capture_writer #(
   parameter int NUM_TILES    = 2,
   parameter int POST_SAMPLES = 192
) (
   input  logic                                      RCLK,
   input  logic                                      reset,
   input  logic                                      arm,          // pulse
   input  logic                                      trigger,      // level
   input  logic                                      sample_valid, // strobe
   input  logic [NUM_TILES*capture_pkg::TILE_W-1:0]  sample,
   input  logic                                      dump_busy,    // blocks arm
   output capture_pkg::wr_ctl_t                      wr,
   output logic [NUM_TILES*capture_pkg::TILE_W-1:0]  wr_data,
   output logic                                      capture_done,
   output logic                                      capturing,
   output logic [capture_pkg::ADDR_W-1:0]            oldest_addr
);
   import capture_pkg::*;

   // terminal counts checked before the increment
   localparam logic [ADDR_W-1:0] PRE_LAST  = ADDR_W'(DEPTH - POST_SAMPLES - 1);
   localparam logic [ADDR_W-1:0] POST_LAST = ADDR_W'(POST_SAMPLES - 1);

   cap_state_e        state;
   logic [ADDR_W-1:0] wr_ptr;                  // next ring slot
   logic [ADDR_W-1:0] pre_cnt;                 // writes before arming
   logic [ADDR_W-1:0] post_cnt;                // trigger counts as 1
   logic              wr_we;
   logic [ADDR_W-1:0] wr_addr;
   logic              take;                    // sample goes into ring
   logic              arm_ok;

   assign capturing   = (state == CAP_PREFILL) || (state == CAP_ARMED) ||
                        (state == CAP_POST);
   assign take        = capturing && sample_valid;
   assign arm_ok      = arm && !dump_busy;     // no rearm under a dump
   assign oldest_addr = wr_ptr;                // wraps onto oldest once stopped
   assign wr          = '{we: wr_we, waddr: wr_addr};

   // ------------------------------
   // capture FSM
   // ------------------------------
   always_ff @(posedge RCLK) begin
      if (reset) begin
         state        <= CAP_IDLE;
         wr_ptr       <= '0;
         pre_cnt      <= '0;
         post_cnt     <= '0;
         wr_we        <= 1'b0;
         capture_done <= 1'b0;
      end else if (arm_ok) begin
         state        <= CAP_PREFILL;          // restart from slot 0
         wr_ptr       <= '0;
         pre_cnt      <= '0;
         post_cnt     <= '0;
         wr_we        <= 1'b0;
         capture_done <= 1'b0;
      end else begin
         wr_we        <= take;                 // write lands one edge later
         capture_done <= (state == CAP_DONE);  // lags state by one edge
         if (take) begin
            wr_ptr <= wr_ptr + 1'b1;           // mod 256 by width
         end
         case (state)
            CAP_PREFILL: begin
               if (sample_valid) begin         // trigger ignored here
                  pre_cnt <= pre_cnt + 1'b1;
                  if (pre_cnt == PRE_LAST) begin
                     state <= CAP_ARMED;
                  end
               end
            end
            CAP_ARMED: begin
               if (sample_valid && trigger) begin
                  post_cnt <= 8'd1;            // trigger sample itself
                  state    <= (POST_SAMPLES == 1) ? CAP_DONE : CAP_POST;
               end
            end
            CAP_POST: begin
               if (sample_valid) begin
                  post_cnt <= post_cnt + 1'b1;
                  if (post_cnt == POST_LAST) begin
                     state <= CAP_DONE;
                  end
               end
            end
            default: ;                         // idle and done drop samples
         endcase
      end
   end

   // write address and data register
   always_ff @(posedge RCLK) begin
      if (take) begin
         wr_addr <= wr_ptr;
         wr_data <= sample;
      end
   end

   a_done_excl : assert property (
      @(posedge RCLK) disable iff (reset) !(capture_done && capturing)
   ) else $error("capture_writer: capture_done and capturing both high");

   // last post sample may still land just after entering done
   a_no_write_done : assert property (
      @(posedge RCLK) disable iff (reset) (state == CAP_DONE) |=> !wr.we
   ) else $error("capture_writer: RAM write while in %s", state.name());

endmodule

/* design/dump_reader.sv */
module dump_reader #(
   parameter int NUM_TILES = 2
) (
   input  logic                                      RCLK,
   input  logic                                      reset,
   input  logic                                      dump_start,  // pulse
   input  logic                                      out_hold,    // consumer stall
   input  logic                                      capture_done,
   input  logic [capture_pkg::ADDR_W-1:0]            oldest_addr,
   output capture_pkg::rd_ctl_t                      rd,
   input  logic [NUM_TILES*capture_pkg::TILE_W-1:0]  ram_dout,
   output logic [NUM_TILES*capture_pkg::TILE_W-1:0]  out_word,
   output logic                                      out_valid,
   output logic                                      dump_busy
);
   import capture_pkg::*;

   localparam logic [ADDR_W:0] LAST_ISSUE = (ADDR_W + 1)'(DEPTH - 1);

   dump_state_e       state;
   logic [ADDR_W-1:0] raddr;                   // walks oldest to newest
   logic [ADDR_W:0]   issue_cnt;               // 9 bits, reaches 256
   logic              ce;

   assign dump_busy = (state != DUMP_IDLE);
   assign ce        = dump_busy && !out_hold;  // hold freezes the pipe
   assign rd        = '{ce: ce, raddr: raddr};
   assign out_word  = ram_dout;                // tile output regs are the stage

   // ------------------------------
   // read sequencer
   // ------------------------------
   always_ff @(posedge RCLK) begin
      if (reset) begin
         state     <= DUMP_IDLE;
         raddr     <= '0;
         issue_cnt <= '0;
      end else begin
         case (state)
            DUMP_IDLE: begin
               if (dump_start && capture_done) begin
                  state     <= DUMP_RUN;
                  raddr     <= oldest_addr;    // first fetch next cycle
                  issue_cnt <= '0;
               end
            end
            DUMP_RUN: begin
               if (!out_hold) begin            // one issue per ce
                  raddr     <= raddr + 1'b1;
                  issue_cnt <= issue_cnt + 1'b1;
                  if (issue_cnt == LAST_ISSUE) begin
                     state <= DUMP_DRAIN;
                  end
               end
            end
            DUMP_DRAIN: begin
               if (!out_hold) begin            // last word taken here
                  state <= DUMP_IDLE;
               end
            end
            default: state <= DUMP_IDLE;
         endcase
      end
   end

   // ------------------------------
   // valid bit
   // ------------------------------
   // tracks the RAM output register, advances only with ce
   always_ff @(posedge RCLK) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (ce) begin
         out_valid <= (state == DUMP_RUN);     // drain fetch is a bubble
      end
   end

   // consumer may see the same word repeatedly under hold
   a_hold_stable : assert property (
      @(posedge RCLK) disable iff (reset) out_hold |=> $stable(out_word)
   ) else $error("dump_reader: out_word changed under out_hold");

endmodule

/* design/capture_top.sv */
module capture_top #(
   parameter int NUM_TILES    = 2,
   parameter int POST_SAMPLES = 192               // 1..255
) (
   input  logic                                      RCLK,
   input  logic                                      reset,
   input  logic                                      arm,
   input  logic                                      trigger,
   input  logic                                      sample_valid,
   input  logic [NUM_TILES*capture_pkg::TILE_W-1:0]  sample,
   input  logic                                      dump_start,
   input  logic                                      out_hold,
   output logic                                      capture_done,
   output logic                                      capturing,
   output logic                                      out_valid,
   output logic [NUM_TILES*capture_pkg::TILE_W-1:0]  out_word,
   output logic                                      dump_busy
);
   import capture_pkg::*;

   wr_ctl_t                         wr;           // shared by every tile
   rd_ctl_t                         rd;           // shared by every tile
   logic [NUM_TILES*TILE_W-1:0]     wr_data;      // lane i to tile i
   logic [NUM_TILES*TILE_W-1:0]     ram_dout;     // tiles side by side
   logic [ADDR_W-1:0]               oldest_addr;

   // ------------------------------
   // write side
   // ------------------------------
   capture_writer #(
      .NUM_TILES    (NUM_TILES),
      .POST_SAMPLES (POST_SAMPLES)
   ) u_writer (
      .RCLK         (RCLK),
      .reset        (reset),
      .arm          (arm),
      .trigger      (trigger),
      .sample_valid (sample_valid),
      .sample       (sample),
      .dump_busy    (dump_busy),
      .wr           (wr),
      .wr_data      (wr_data),
      .capture_done (capture_done),
      .capturing    (capturing),
      .oldest_addr  (oldest_addr)
   );

   // ------------------------------
   // read side
   // ------------------------------
   dump_reader #(
      .NUM_TILES    (NUM_TILES)
   ) u_reader (
      .RCLK         (RCLK),
      .reset        (reset),
      .dump_start   (dump_start),
      .out_hold     (out_hold),
      .capture_done (capture_done),
      .oldest_addr  (oldest_addr),
      .rd           (rd),
      .ram_dout     (ram_dout),
      .out_word     (out_word),
      .out_valid    (out_valid),
      .dump_busy    (dump_busy)
   );

   // one 36 bit tile per lane
   for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
      ramb8x36_sdp u_tile (
         .RCLK  (RCLK),
         .we    (wr.we),
         .waddr (wr.waddr),
         .din   (wr_data[i*TILE_W +: TILE_W]),
         .ce    (rd.ce),
         .raddr (rd.raddr),
         .dout  (ram_dout[i*TILE_W +: TILE_W])
      );
   end

endmodule

/* test/capture_checker.sv */
module capture_checker #(
   parameter int NUM_TILES    = 2,
   parameter int POST_SAMPLES = 192
) (
   input  logic                                     RCLK,
   input  logic                                     reset,
   input  logic                                     arm,
   input  logic                                     trigger,
   input  logic                                     sample_valid,
   input  logic                                     dump_start,
   input  logic                                     out_hold,
   input  logic                                     capture_done,
   input  logic                                     capturing,
   input  logic                                     out_valid,
   input  logic [NUM_TILES*capture_pkg::TILE_W-1:0] out_word,
   input  logic                                     dump_busy,
   output int                                       value_errs,
   output int                                       other_errs,
   output int                                       dumps_done
);
   timeunit 1ns;
   timeprecision 100ps;
   import capture_pkg::*;

   localparam int PRE = DEPTH - POST_SAMPLES;  // ring slots before the trigger

   cap_state_e                  m_state;       // model of the capture FSM
   logic                        m_done;
   logic                        exp_cap;
   logic                        dump_on;       // model of dump_busy
   logic                        busy_q;        // dump_busy before this edge
   logic                        first_hold;
   logic [NUM_TILES*TILE_W-1:0] exp_w;
   int                          n_seen;        // valid strobes since reset
   int                          pre_cnt;
   int                          post_cnt;
   int                          base_idx;      // sample index of dump word 0
   int                          taken;
   int                          since_start;   // edges since dump accepted

   task automatic value_error(string name, logic [127:0] exp, logic [127:0] act);
      value_errs++;
      $display("** Error %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
   endtask

   task automatic other_error(string msg);
      other_errs++;
      $display("%0t ns: %s", $time, msg);
   endtask

   // lane i of sample n carries n*16+i
   function automatic logic [NUM_TILES*TILE_W-1:0] expected_word(int idx);
      logic [NUM_TILES*TILE_W-1:0] w;
      for (int i = 0; i < NUM_TILES; i++) begin
         w[i*TILE_W +: TILE_W] = TILE_W'(idx * 16 + i);
      end
      return w;
   endfunction

   initial begin
      value_errs = 0;
      other_errs = 0;
      dumps_done = 0;
   end

   // ------------------------------
   // reference model
   // ------------------------------
   always @(posedge RCLK) begin
      if (reset) begin
         m_state     = CAP_IDLE;
         m_done      = 1'b0;
         dump_on     = 1'b0;
         first_hold  = 1'b0;
         n_seen      = 0;
         pre_cnt     = 0;
         post_cnt    = 0;
         base_idx    = 0;
         taken       = 0;
         since_start = 0;
      end else begin
         exp_cap = m_state inside {CAP_PREFILL, CAP_ARMED, CAP_POST};
         assert (capturing === exp_cap)
            else value_error($sformatf("capturing (%s)", m_state.name()), exp_cap, capturing);
         assert (capture_done === m_done) else value_error("capture_done", m_done, capture_done);
         assert (dump_busy === dump_on) else value_error("dump_busy", dump_on, dump_busy);
         if (!dump_on) begin
            assert (out_valid === 1'b0) else value_error("out_valid", 1'b0, out_valid);
         end
         busy_q = dump_on;
         if (dump_on) begin
            since_start++;
         end
         if (dump_on && since_start == 1) begin       // first issue edge
            assert (out_valid === 1'b0) else value_error("out_valid", 1'b0, out_valid);
            first_hold = out_hold;
         end
         if (dump_on && since_start == 2) begin       // first word due unless held
            assert (out_valid === !first_hold)
               else value_error("out_valid", !first_hold, out_valid);
         end
         if (dump_on && out_valid && !out_hold) begin // consumer takes a word
            exp_w = expected_word(base_idx + taken);
            assert (out_word === exp_w) else value_error("out_word", exp_w, out_word);
            taken++;
            if (taken == DEPTH) begin
               dump_on = 1'b0;
               dumps_done++;
            end
         end
         if (!busy_q && dump_start && m_done) begin
            dump_on     = 1'b1;
            taken       = 0;
            since_start = 0;
         end
         // capture side uses the state before this edge
         if (arm && !busy_q) begin
            m_state  = CAP_PREFILL;
            pre_cnt  = 0;
            post_cnt = 0;
            m_done   = 1'b0;
         end else begin
            m_done = (m_state == CAP_DONE);           // one edge after the last post
            if (sample_valid) begin
               case (m_state)
                  CAP_PREFILL: begin
                     pre_cnt++;                       // trigger ignored
                     if (pre_cnt == PRE) begin
                        m_state = CAP_ARMED;
                     end
                  end
                  CAP_ARMED: begin
                     if (trigger) begin
                        base_idx = n_seen - PRE;
                        post_cnt = 1;                 // trigger is post sample 1
                        m_state  = (POST_SAMPLES == 1) ? CAP_DONE : CAP_POST;
                     end
                  end
                  CAP_POST: begin
                     post_cnt++;
                     if (post_cnt == POST_SAMPLES) begin
                        m_state = CAP_DONE;
                     end
                  end
                  default: ;                          // not stored
               endcase
            end
         end
         if (sample_valid) begin
            n_seen++;
         end
      end
   end

   // ------------------------------
   // port properties
   // ------------------------------
   hold_keeps_word : assert property (
      @(posedge RCLK) disable iff (reset)
      (out_valid && out_hold) |=> ($stable(out_word) && out_valid)
   ) else other_error("out_word or out_valid moved while out_hold was high");

   done_not_capturing : assert property (
      @(posedge RCLK) disable iff (reset) !(capture_done && capturing)
   ) else other_error("capture_done and capturing were high together");

endmodule

/* test/capture_tb.sv */
module capture_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import capture_pkg::*;

   localparam int NUM_TILES    = 2;
   localparam int POST_SAMPLES = 192;
   localparam int PRE          = DEPTH - POST_SAMPLES;
   localparam int TRIG1        = PRE + 40;          // accepted trigger of capture 1
   localparam int TRIG2        = PRE + 7;           // accepted trigger of capture 2
   localparam int EXTRA        = 50;                // samples after done
   localparam int CAP1_N       = TRIG1 + POST_SAMPLES;
   localparam int CAP2_N       = TRIG2 + POST_SAMPLES;
   localparam int TOTAL_N      = CAP1_N + EXTRA + CAP2_N;
   localparam longint WATCHDOG_NS = longint'(TOTAL_N + 3 * DEPTH) * 4 * 40 + 400 * 40;

   logic                        RCLK;
   logic                        reset;
   logic                        arm;
   logic                        trigger;
   logic                        sample_valid;
   logic [NUM_TILES*TILE_W-1:0] sample;
   logic                        dump_start;
   logic                        out_hold;
   logic                        capture_done;
   logic                        capturing;
   logic                        out_valid;
   logic [NUM_TILES*TILE_W-1:0] out_word;
   logic                        dump_busy;
   int                          value_errs;
   int                          other_errs;
   int                          dumps_done;
   int                          tb_errs;
   int                          sample_idx;        // global sample index

   always #20 RCLK = ~RCLK;                        // 40 ns period

   capture_top #(
      .NUM_TILES    (NUM_TILES),
      .POST_SAMPLES (POST_SAMPLES)
   ) u_capture_top (
      .RCLK, .reset, .arm, .trigger, .sample_valid, .sample, .dump_start, .out_hold,
      .capture_done, .capturing, .out_valid, .out_word, .dump_busy
   );

   capture_checker #(
      .NUM_TILES    (NUM_TILES),
      .POST_SAMPLES (POST_SAMPLES)
   ) u_check (
      .RCLK, .reset, .arm, .trigger, .sample_valid, .dump_start, .out_hold,
      .capture_done, .capturing, .out_valid, .out_word, .dump_busy,
      .value_errs, .other_errs, .dumps_done
   );

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic cycle();
      @(posedge RCLK);
      #2;                                          // drive just after the edge
   endtask

   function automatic logic [NUM_TILES*TILE_W-1:0] pattern(int n);
      logic [NUM_TILES*TILE_W-1:0] w;
      for (int i = 0; i < NUM_TILES; i++) begin
         w[i*TILE_W +: TILE_W] = TILE_W'(n * 16 + i);
      end
      return w;
   endfunction

   task automatic push_sample(input logic trig);
      sample_valid = 1'b1;
      trigger      = trig;
      sample       = pattern(sample_idx);
      sample_idx++;
      cycle();
      sample_valid = 1'b0;
      trigger      = 1'b0;
   endtask

   task automatic pulse_arm();
      arm = 1'b1;
      cycle();
      arm = 1'b0;
   endtask

   task automatic pulse_dump_start();
      dump_start = 1'b1;
      cycle();
      dump_start = 1'b0;
   endtask

   // early trigger burst in prefill and a stray dump_start at early_dump
   task automatic capture_run(int n, int trig_at, int gap_pct, int early_dump);
      int gaps;
      for (int j = 0; j < n; j++) begin
         gaps = (gap_pct > 0 && $urandom_range(99) < gap_pct) ? $urandom_range(3, 1) : 0;
         repeat (gaps) begin
            trigger = 1'($urandom_range(1));       // no valid so never taken
            cycle();
         end
         dump_start = (j == early_dump);
         push_sample((j >= 10 && j < 30) || j == trig_at);
         dump_start = 1'b0;
      end
   endtask

   task automatic wait_done();
      int guard;
      guard = 0;
      while (!capture_done && guard < 20) begin
         cycle();
         guard++;
      end
      if (!capture_done) begin
         tb_errs++;
         $display("%0t ns: capture_done did not rise after the last post sample", $time);
      end
   endtask

   task automatic dump_run(int hold_pct);
      int guard;
      guard = 0;
      pulse_dump_start();
      while (dump_busy && guard < 8 * DEPTH) begin
         out_hold = ($urandom_range(99) < hold_pct);
         cycle();
         guard++;
      end
      out_hold = 1'b0;
      if (dump_busy) begin
         tb_errs++;
         $display("%0t ns: dump did not finish in time", $time);
      end
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      RCLK         = 1'b0;
      reset        = 1'b1;
      arm          = 1'b0;
      trigger      = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      dump_start   = 1'b0;
      out_hold     = 1'b0;
      sample_idx   = 0;
      tb_errs      = 0;
      void'($urandom(32'h2dd5));
      repeat (16) @(posedge RCLK);
      #2;
      reset = 1'b0;
      repeat (4) cycle();                          // outputs quiet after reset
      pulse_dump_start();                          // nothing captured yet
      pulse_arm();
      capture_run(CAP1_N, TRIG1, 0, 5);            // back to back samples
      wait_done();
      dump_run(0);
      repeat (EXTRA) push_sample(1'b1);            // dropped after done
      dump_run(30);                                // same words under back-pressure
      pulse_arm();
      capture_run(CAP2_N, TRIG2, 60, 100);         // sparse samples
      wait_done();
      dump_run(30);
      repeat (4) cycle();
      if (dumps_done != 3) begin
         tb_errs++;
         $display("only %0d of 3 dumps completed", dumps_done);
      end
      $display("errors: %0d value, %0d other, %0d testbench", value_errs, other_errs, tb_errs);
      if (value_errs + other_errs + tb_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t ns, the run is stuck", $time);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* tb.f */
design/capture_pkg.sv
design/ramb8x36_sdp.sv
design/capture_writer.sv
design/dump_reader.sv
design/capture_top.sv
test/capture_checker.sv
test/capture_tb.sv
